/* rtl/gyruss_defines.svh */
// Gyruss CPU glue parameters
`ifndef GYRUSS_DEFINES_SVH
`define GYRUSS_DEFINES_SVH

// ============================================================
// CPU buses
// ============================================================

// Address width shared by the Z80 and the KONAMI-1
`define GYRUSS_ADDR_W 16

// Both CPUs move bytes
`define GYRUSS_DATA_W 8

// Value returned for any unmapped read
`define GYRUSS_OPEN_BUS 8'hFF

// ============================================================
// Memories and clocking
// ============================================================

// Work RAM is two 2K banks, selected by A11
`define GYRUSS_WRAM_AW 12

// Shared RAM is 2K, mirrored across both CPU windows
`define GYRUSS_SRAM_AW 11

// Divider width; the low four bits set the 16-clock CPU phase
`define GYRUSS_DIV_W 5

`endif

/* rtl/gyruss_pkg.sv */
// Gyruss CPU glue types
`default_nettype none

package gyruss_pkg;

	// Z80 regions, picked from the high address bits
	typedef enum logic [2:0] {
		MAIN_ROM,
		MAIN_WRAM,
		MAIN_SHARED,
		MAIN_IO,
		MAIN_NONE
	} main_region_e;

	// KONAMI-1 regions, one per 8K block in use
	typedef enum logic [2:0] {
		SUB_BEAM,
		SUB_IRQMASK,
		SUB_SHARED,
		SUB_ROM,
		SUB_NONE
	} sub_region_e;

	// Z80 I/O function from A8:A7
	// Reads and writes share a code but not a function
	typedef enum logic [1:0] {
		DIP2_SEL       = 2'b00,
		CTRL_IRQ_SEL   = 2'b01,
		DIP3_SOUND_SEL = 2'b10,
		LATCH_SEL      = 2'b11
	} io_sel_e;

endpackage

`default_nettype wire

/* rtl/ram_port_if.sv */
// RAM port interface
`default_nettype none
`include "gyruss_defines.svh"

// One synchronous RAM port
// Write enable already folds in the CPU clock enable
interface ram_port_if #(
	parameter int ADDR_W = `GYRUSS_SRAM_AW
);

	logic [ADDR_W-1:0]         addr;
	logic [`GYRUSS_DATA_W-1:0] wdata;
	logic                      we;

	// Registered in the memory, one clock after addr
	logic [`GYRUSS_DATA_W-1:0] rdata;

	// Bus decoder side
	modport ctrl (
		output addr,
		output wdata,
		output we,
		input  rdata
	);

	// Memory side
	modport mem (
		input  addr,
		input  wdata,
		input  we,
		output rdata
	);

endinterface

`default_nettype wire

/* rtl/clock_enable_gen.sv */
// CPU clock enable generator
`default_nettype none
`include "gyruss_defines.svh"

module clock_enable_gen (
	input  wire  clk_49m,
	input  wire  reset,
	output logic cen_main_o,
	output logic cen_sub_o
);

	// Low bits of the divider form the 16-clock CPU phase
	localparam int PHASE_W = `GYRUSS_DIV_W - 1;

	// Z80 enable at phase 0, KONAMI-1 E phase halfway round
	localparam logic [PHASE_W-1:0] MAIN_PHASE = '0;
	localparam logic [PHASE_W-1:0] SUB_PHASE  = PHASE_W'(8);

	logic [`GYRUSS_DIV_W-1:0] div;
	logic [PHASE_W-1:0]       next_phase;

	// Free-running 49.152 MHz divider
	always_ff @(posedge clk_49m) begin
		if (!reset)
			div <= '0;
		else
			div <= div + 1'b1;
	end

	// Phase the divider moves to on this edge
	assign next_phase = div[PHASE_W-1:0] + 1'b1;

	// Enables are registered so they line up with the count
	// 3.072 MHz for the Z80, same rate for the E phase
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			cen_main_o <= 1'b0;
			cen_sub_o  <= 1'b0;
		end else begin
			cen_main_o <= (next_phase == MAIN_PHASE);
			cen_sub_o  <= (next_phase == SUB_PHASE);
		end
	end

endmodule

`default_nettype wire

/* rtl/main_bus_decoder.sv */
// Z80 bus decoder
`default_nettype none
`include "gyruss_defines.svh"

module main_bus_decoder (
	input  wire                        clk_49m,
	input  wire                        reset,
	input  wire                        cen_i,
	// Z80 bus
	input  wire  [`GYRUSS_ADDR_W-1:0]  addr_i,
	input  wire  [`GYRUSS_DATA_W-1:0]  wdata_i,
	input  wire                        mreq_i,
	input  wire                        wr_i,
	output logic [`GYRUSS_DATA_W-1:0]  rdata_o,
	// Program ROM
	output logic [`GYRUSS_ADDR_W-2:0]  rom_addr_o,
	input  wire  [`GYRUSS_DATA_W-1:0]  rom_data_i,
	// Inputs and video status
	input  wire  [`GYRUSS_DATA_W-1:0]  controls_dip_i,
	input  wire                        vblank_i,
	// Interrupt, flip and sound board
	output logic                       nmi_n_o,
	output logic                       flip_o,
	output logic                       cs_sounddata_o,
	output logic                       irq_trigger_o,
	output logic [`GYRUSS_DATA_W-1:0]  sound_data_o,
	// Memories
	ram_port_if.ctrl                   wram_port,
	ram_port_if.ctrl                   sram_a
);

	gyruss_pkg::main_region_e region;
	gyruss_pkg::io_sel_e      io_sel;

	logic io_wr;
	logic cs_latch;
	logic cs_soundirq;
	logic nmi_mask;

	// ============================================================
	// Address decode
	// ============================================================

	always_comb begin
		if (!mreq_i)
			region = gyruss_pkg::MAIN_NONE;
		// 0000-5FFF, three 8K ROMs
		else if (addr_i[15:13] <= 3'b010)
			region = gyruss_pkg::MAIN_ROM;
		// 9000-9FFF, two work RAM banks
		else if (addr_i[15:12] == 4'h9)
			region = gyruss_pkg::MAIN_WRAM;
		// A000-BFFF, 2K mirrored
		else if (addr_i[15:13] == 3'b101)
			region = gyruss_pkg::MAIN_SHARED;
		else if (addr_i[15:14] == 2'b11)
			region = gyruss_pkg::MAIN_IO;
		else
			region = gyruss_pkg::MAIN_NONE;
	end

	// I/O function within C000-FFFF
	assign io_sel = gyruss_pkg::io_sel_e'(addr_i[8:7]);

	assign io_wr       = (region == gyruss_pkg::MAIN_IO) && wr_i;
	assign cs_latch    = io_wr && (io_sel == gyruss_pkg::LATCH_SEL);
	assign cs_soundirq = io_wr && (io_sel == gyruss_pkg::CTRL_IRQ_SEL);

	// Sound board strobe and data, live for the whole write cycle
	assign cs_sounddata_o = io_wr && (io_sel == gyruss_pkg::DIP3_SOUND_SEL);
	assign sound_data_o   = wdata_i;

	// ============================================================
	// Memory ports and read data
	// ============================================================

	assign rom_addr_o = addr_i[`GYRUSS_ADDR_W-2:0];

	// A11 lands in the top bit and picks the bank
	assign wram_port.addr  = addr_i[`GYRUSS_WRAM_AW-1:0];
	assign wram_port.wdata = wdata_i;
	assign wram_port.we    = cen_i && wr_i && (region == gyruss_pkg::MAIN_WRAM);

	assign sram_a.addr  = addr_i[`GYRUSS_SRAM_AW-1:0];
	assign sram_a.wdata = wdata_i;
	assign sram_a.we    = cen_i && wr_i && (region == gyruss_pkg::MAIN_SHARED);

	always_comb begin
		case (region)
			gyruss_pkg::MAIN_ROM:    rdata_o = rom_data_i;
			gyruss_pkg::MAIN_WRAM:   rdata_o = wram_port.rdata;
			gyruss_pkg::MAIN_SHARED: rdata_o = sram_a.rdata;
			// DIP2, controls and DIP3 share one input byte
			gyruss_pkg::MAIN_IO:
				rdata_o = (io_sel == gyruss_pkg::LATCH_SEL) ? `GYRUSS_OPEN_BUS : controls_dip_i;
			default:                 rdata_o = `GYRUSS_OPEN_BUS;
		endcase
	end

	// ============================================================
	// Main latch, sound IRQ and NMI
	// ============================================================

	// Latch bit picked by A2:A0, value from D0
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			nmi_mask <= 1'b0;
			flip_o   <= 1'b0;
		end else if (cen_i && cs_latch) begin
			case (addr_i[2:0])
				3'd0:    nmi_mask <= wdata_i[0];
				3'd5:    flip_o   <= wdata_i[0];
				default: ;
			endcase
		end
	end

	// Held for one whole Z80 enable period
	always_ff @(posedge clk_49m) begin
		if (!reset)
			irq_trigger_o <= 1'b0;
		else if (cen_i)
			irq_trigger_o <= cs_soundirq;
	end

	// NMI drops on vblank and holds until the mask is cleared
	always_ff @(posedge clk_49m) begin
		if (!reset)
			nmi_n_o <= 1'b1;
		else if (!nmi_mask)
			nmi_n_o <= 1'b1;
		else if (vblank_i)
			nmi_n_o <= 1'b0;
	end

endmodule

`default_nettype wire

/* rtl/sub_bus_decoder.sv */
// KONAMI-1 bus decoder
`default_nettype none
`include "gyruss_defines.svh"

module sub_bus_decoder (
	input  wire                        clk_49m,
	input  wire                        reset,
	input  wire                        cen_i,
	// KONAMI-1 bus
	input  wire  [`GYRUSS_ADDR_W-1:0]  addr_i,
	input  wire  [`GYRUSS_DATA_W-1:0]  wdata_i,
	input  wire                        wr_i,
	output logic [`GYRUSS_DATA_W-1:0]  rdata_o,
	// Program ROM, 8K
	output logic [12:0]                rom_addr_o,
	input  wire  [`GYRUSS_DATA_W-1:0]  rom_data_i,
	// Video timing
	input  wire  [`GYRUSS_DATA_W-1:0]  v_cnt_i,
	input  wire                        vblank_i,
	output logic                       irq_n_o,
	// Shared RAM port B
	ram_port_if.ctrl                   sram_b
);

	gyruss_pkg::sub_region_e region;

	logic irq_mask;

	// ============================================================
	// Address decode, one region per 8K block
	// ============================================================

	always_comb begin
		case (addr_i[15:13])
			3'b000:  region = gyruss_pkg::SUB_BEAM;
			3'b001:  region = gyruss_pkg::SUB_IRQMASK;
			3'b011:  region = gyruss_pkg::SUB_SHARED;
			3'b111:  region = gyruss_pkg::SUB_ROM;
			// Sprite RAM block and the rest read open bus
			default: region = gyruss_pkg::SUB_NONE;
		endcase
	end

	assign rom_addr_o = addr_i[12:0];

	// 6000-7FFF mirrors the 2K shared RAM
	assign sram_b.addr  = addr_i[`GYRUSS_SRAM_AW-1:0];
	assign sram_b.wdata = wdata_i;
	assign sram_b.we    = cen_i && wr_i && (region == gyruss_pkg::SUB_SHARED);

	always_comb begin
		case (region)
			// Beam position, the vertical count
			gyruss_pkg::SUB_BEAM:   rdata_o = v_cnt_i;
			gyruss_pkg::SUB_SHARED: rdata_o = sram_b.rdata;
			gyruss_pkg::SUB_ROM:    rdata_o = rom_data_i;
			default:                rdata_o = `GYRUSS_OPEN_BUS;
		endcase
	end

	// ============================================================
	// IRQ mask and VBlank IRQ
	// ============================================================

	// Mask from D0 on any write to 2000-3FFF
	always_ff @(posedge clk_49m) begin
		if (!reset)
			irq_mask <= 1'b0;
		else if (cen_i && wr_i && (region == gyruss_pkg::SUB_IRQMASK))
			irq_mask <= wdata_i[0];
	end

	// Cleared mask releases the line on the next clock
	always_ff @(posedge clk_49m) begin
		if (!reset)
			irq_n_o <= 1'b1;
		else if (!irq_mask)
			irq_n_o <= 1'b1;
		else if (vblank_i)
			irq_n_o <= 1'b0;
	end

endmodule

`default_nettype wire

/* rtl/work_ram.sv */
// Z80 work RAM
`default_nettype none
`include "gyruss_defines.svh"

module work_ram #(
	parameter int ADDR_W = `GYRUSS_WRAM_AW
) (
	input  wire      clk_49m,
	ram_port_if.mem  port
);

	localparam int DEPTH = 2 ** ADDR_W;

	logic [`GYRUSS_DATA_W-1:0] mem [DEPTH];

	// Read on the write edge returns the old byte
	always_ff @(posedge clk_49m) begin
		if (port.we)
			mem[port.addr] <= port.wdata;
	end

	// Registered read, valid one clock after the address
	always_ff @(posedge clk_49m) begin
		port.rdata <= mem[port.addr];
	end

endmodule

`default_nettype wire

/* rtl/shared_ram.sv */
// Dual-port shared RAM
`default_nettype none
`include "gyruss_defines.svh"

module shared_ram (
	input  wire      clk_49m,
	// Z80 side
	ram_port_if.mem  port_a,
	// KONAMI-1 side
	ram_port_if.mem  port_b
);

	localparam int DEPTH = 2 ** `GYRUSS_SRAM_AW;

	logic [`GYRUSS_DATA_W-1:0] mem [DEPTH];

	// Both sides write the same array
	// Port B lands last when both hit one address on the same edge
	always_ff @(posedge clk_49m) begin
		if (port_a.we)
			mem[port_a.addr] <= port_a.wdata;
		if (port_b.we)
			mem[port_b.addr] <= port_b.wdata;
	end

	// Independent registered reads
	always_ff @(posedge clk_49m) begin
		port_a.rdata <= mem[port_a.addr];
		port_b.rdata <= mem[port_b.addr];
	end

endmodule

`default_nettype wire

/* rtl/gyruss_cpu_glue.sv */
// Gyruss CPU glue top level
`default_nettype none
`include "gyruss_defines.svh"

module gyruss_cpu_glue (
	input  wire                        clk_49m,
	input  wire                        reset,
	// Z80 bus
	input  wire  [`GYRUSS_ADDR_W-1:0]  main_addr_i,
	input  wire  [`GYRUSS_DATA_W-1:0]  main_wdata_i,
	input  wire                        main_mreq_i,
	input  wire                        main_wr_i,
	output logic [`GYRUSS_DATA_W-1:0]  main_rdata_o,
	output logic [`GYRUSS_ADDR_W-2:0]  main_rom_addr_o,
	input  wire  [`GYRUSS_DATA_W-1:0]  main_rom_data_i,
	// KONAMI-1 bus
	input  wire  [`GYRUSS_ADDR_W-1:0]  sub_addr_i,
	input  wire  [`GYRUSS_DATA_W-1:0]  sub_wdata_i,
	input  wire                        sub_wr_i,
	output logic [`GYRUSS_DATA_W-1:0]  sub_rdata_o,
	output logic [12:0]                sub_rom_addr_o,
	input  wire  [`GYRUSS_DATA_W-1:0]  sub_rom_data_i,
	// Player inputs and video timing
	input  wire  [`GYRUSS_DATA_W-1:0]  controls_dip_i,
	input  wire  [`GYRUSS_DATA_W-1:0]  v_cnt_i,
	input  wire                        vblank_i,
	// Enables, interrupts and flip
	output logic                       cen_main_o,
	output logic                       cen_sub_o,
	output logic                       nmi_n_o,
	output logic                       irq_n_o,
	output logic                       flip_o,
	// Sound board
	output logic                       cs_sounddata_o,
	output logic                       irq_trigger_o,
	output logic [`GYRUSS_DATA_W-1:0]  sound_data_o
);

	// ============================================================
	// RAM ports
	// ============================================================

	ram_port_if #(.ADDR_W(`GYRUSS_WRAM_AW)) wram_bus ();
	ram_port_if #(.ADDR_W(`GYRUSS_SRAM_AW)) sram_a_bus ();
	ram_port_if #(.ADDR_W(`GYRUSS_SRAM_AW)) sram_b_bus ();

	// ============================================================
	// Clock enables
	// ============================================================

	clock_enable_gen u_cen_gen (
		.clk_49m    (clk_49m),
		.reset      (reset),
		.cen_main_o (cen_main_o),
		.cen_sub_o  (cen_sub_o)
	);

	// ============================================================
	// Bus decoders
	// ============================================================

	// Z80 samples on the 3.072 MHz enable
	main_bus_decoder u_main_dec (
		.clk_49m        (clk_49m),
		.reset          (reset),
		.cen_i          (cen_main_o),
		.addr_i         (main_addr_i),
		.wdata_i        (main_wdata_i),
		.mreq_i         (main_mreq_i),
		.wr_i           (main_wr_i),
		.rdata_o        (main_rdata_o),
		.rom_addr_o     (main_rom_addr_o),
		.rom_data_i     (main_rom_data_i),
		.controls_dip_i (controls_dip_i),
		.vblank_i       (vblank_i),
		.nmi_n_o        (nmi_n_o),
		.flip_o         (flip_o),
		.cs_sounddata_o (cs_sounddata_o),
		.irq_trigger_o  (irq_trigger_o),
		.sound_data_o   (sound_data_o),
		.wram_port      (wram_bus.ctrl),
		.sram_a         (sram_a_bus.ctrl)
	);

	// KONAMI-1 samples on its E phase
	sub_bus_decoder u_sub_dec (
		.clk_49m    (clk_49m),
		.reset      (reset),
		.cen_i      (cen_sub_o),
		.addr_i     (sub_addr_i),
		.wdata_i    (sub_wdata_i),
		.wr_i       (sub_wr_i),
		.rdata_o    (sub_rdata_o),
		.rom_addr_o (sub_rom_addr_o),
		.rom_data_i (sub_rom_data_i),
		.v_cnt_i    (v_cnt_i),
		.vblank_i   (vblank_i),
		.irq_n_o    (irq_n_o),
		.sram_b     (sram_b_bus.ctrl)
	);

	// ============================================================
	// Memories
	// ============================================================

	work_ram #(.ADDR_W(`GYRUSS_WRAM_AW)) u_work_ram (
		.clk_49m (clk_49m),
		.port    (wram_bus.mem)
	);

	shared_ram u_shared_ram (
		.clk_49m (clk_49m),
		.port_a  (sram_a_bus.mem),
		.port_b  (sram_b_bus.mem)
	);

endmodule

`default_nettype wire

/* tb/gyruss_cpu_glue_checker.sv */
// Bound strobe and interrupt checks
`default_nettype none
`include "gyruss_defines.svh"

module gyruss_cpu_glue_checker (
	input wire                      clk_49m,
	input wire                      reset,
	input wire                      cen_main_i,
	input wire                      cen_sub_i,
	input wire [`GYRUSS_ADDR_W-1:0] main_addr_i,
	input wire [`GYRUSS_DATA_W-1:0] main_wdata_i,
	input wire                      main_mreq_i,
	input wire                      main_wr_i,
	input wire                      nmi_n_i,
	input wire                      cs_sounddata_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// Failed assertion count
	int assert_errors = 0;

	// NMI mask as the Z80 last wrote it
	logic mask_model;
	logic io_wr;

	// Z80 write cycle into C000-FFFF
	assign io_wr = main_mreq_i && main_wr_i && (main_addr_i[15:14] == 2'b11);

	// Mask bit sits at A8:A7 of 3 and A2:A0 of 0
	always_ff @(posedge clk_49m) begin
		if (!reset)
			mask_model <= 1'b0;
		else if (cen_main_i && io_wr && (main_addr_i[8:7] == 2'b11) &&
				(main_addr_i[2:0] == 3'd0))
			mask_model <= main_wdata_i[0];
	end

	// ============================================================
	// Clock enables
	// ============================================================

	// Each enable lasts one clock
	main_width: assert property (@(posedge clk_49m) disable iff (!reset)
		cen_main_i |=> !cen_main_i)
	else begin
		assert_errors++;
		$error("cen_main_o held high for more than one clock");
	end

	sub_width: assert property (@(posedge clk_49m) disable iff (!reset)
		cen_sub_i |=> !cen_sub_i)
	else begin
		assert_errors++;
		$error("cen_sub_o held high for more than one clock");
	end

	// E phase sits halfway between Z80 enables
	main_to_sub: assert property (@(posedge clk_49m) disable iff (!reset)
		cen_main_i |-> ##8 cen_sub_i)
	else begin
		assert_errors++;
		$error("cen_sub_o did not follow cen_main_o by 8 clocks");
	end

	// ============================================================
	// NMI and sound strobe
	// ============================================================

	// NMI line stays high while the mask is clear
	nmi_masked: assert property (@(posedge clk_49m) disable iff (!reset)
		!mask_model |=> nmi_n_i)
	else begin
		assert_errors++;
		$error("nmi_n_o went low with the NMI mask clear");
	end

	// Sound data select only inside a Z80 write to A8:A7 of 2
	sound_on_write: assert property (@(posedge clk_49m) disable iff (!reset)
		cs_sounddata_i |-> (io_wr && (main_addr_i[8:7] == 2'b10)))
	else begin
		assert_errors++;
		$error("cs_sounddata_o high outside a Z80 sound data write");
	end

endmodule

bind gyruss_cpu_glue gyruss_cpu_glue_checker u_checker (
	.clk_49m        (clk_49m),
	.reset          (reset),
	.cen_main_i     (cen_main_o),
	.cen_sub_i      (cen_sub_o),
	.main_addr_i    (main_addr_i),
	.main_wdata_i   (main_wdata_i),
	.main_mreq_i    (main_mreq_i),
	.main_wr_i      (main_wr_i),
	.nmi_n_i        (nmi_n_o),
	.cs_sounddata_i (cs_sounddata_o)
);

`default_nettype wire

/* tb/tb_gyruss_cpu_glue.sv */
// Gyruss CPU glue testbench
`default_nettype none
`include "gyruss_defines.svh"

module tb_gyruss_cpu_glue;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 16;
	localparam int CLK_HALF     = 4;

	// Bus an entry drives
	localparam int CPU_MAIN = 0;
	localparam int CPU_SUB  = 1;

	// Check made by an entry
	// Status checks from CK_TRIG upward run after the write edge
	localparam int CK_NONE  = 0;
	localparam int CK_READ  = 1;
	localparam int CK_ROM   = 2;
	localparam int CK_SOUND = 3;
	localparam int CK_TRIG  = 4;
	localparam int CK_FLIP  = 5;
	localparam int CK_NMI   = 6;
	localparam int CK_IRQ   = 7;

	typedef struct {
		string                     name;
		int                        cpu;
		logic [`GYRUSS_ADDR_W-1:0] addr;
		bit                        wr;
		logic [`GYRUSS_DATA_W-1:0] data;
		logic [`GYRUSS_DATA_W-1:0] exp;
		int                        check;
		bit                        vblank;
	} test_t;

	logic                      clk_49m;
	logic                      reset;
	logic [`GYRUSS_ADDR_W-1:0] main_addr_i;
	logic [`GYRUSS_DATA_W-1:0] main_wdata_i;
	logic                      main_mreq_i;
	logic                      main_wr_i;
	logic [`GYRUSS_DATA_W-1:0] main_rdata_o;
	logic [`GYRUSS_ADDR_W-2:0] main_rom_addr_o;
	logic [`GYRUSS_DATA_W-1:0] main_rom_data_i;
	logic [`GYRUSS_ADDR_W-1:0] sub_addr_i;
	logic [`GYRUSS_DATA_W-1:0] sub_wdata_i;
	logic                      sub_wr_i;
	logic [`GYRUSS_DATA_W-1:0] sub_rdata_o;
	logic [12:0]               sub_rom_addr_o;
	logic [`GYRUSS_DATA_W-1:0] sub_rom_data_i;
	logic [`GYRUSS_DATA_W-1:0] controls_dip_i;
	logic [`GYRUSS_DATA_W-1:0] v_cnt_i;
	logic                      vblank_i;
	logic                      cen_main_o;
	logic                      cen_sub_o;
	logic                      nmi_n_o;
	logic                      irq_n_o;
	logic                      flip_o;
	logic                      cs_sounddata_o;
	logic                      irq_trigger_o;
	logic [`GYRUSS_DATA_W-1:0] sound_data_o;

	test_t tests[$];
	bit    table_ready = 1'b0;
	bit    main_edge   = 1'b0;
	bit    sub_edge    = 1'b0;
	int    checks      = 0;
	int    errors      = 0;

	gyruss_cpu_glue dut (.*);

	// ============================================================
	// Clock, ROM models and enable tracking
	// ============================================================

	initial begin
		clk_49m = 1'b0;
		forever #CLK_HALF clk_49m = ~clk_49m;
	end

	// Program ROMs answer with the low address byte inverted
	assign main_rom_data_i = ~main_rom_addr_o[7:0];
	assign sub_rom_data_i  = ~sub_rom_addr_o[7:0];

	// High through the low half clock after an enable edge
	always @(posedge clk_49m) begin
		main_edge <= cen_main_o;
		sub_edge  <= cen_sub_o;
	end

	function automatic logic [7:0] rom_byte(input logic [15:0] addr);
		return ~addr[7:0];
	endfunction

	function automatic logic cen_of(input int cpu);
		return (cpu == CPU_MAIN) ? cen_main_o : cen_sub_o;
	endfunction

	task automatic add_test(input string name, input int cpu, input logic [15:0] addr,
		input bit wr, input logic [7:0] data, input logic [7:0] exp, input int check,
		input bit vblank);
		tests.push_back(test_t'{name, cpu, addr, wr, data, exp, check, vblank});
	endtask

	task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error: %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// ============================================================
	// Bus model
	// ============================================================

	// Called on a falling edge, parks just after an enable
	task automatic wait_enable(input int cpu);
		while ((cpu == CPU_MAIN) ? !main_edge : !sub_edge)
			@(negedge clk_49m);
	endtask

	task automatic drive_bus(input test_t t);
		if (t.cpu == CPU_MAIN) begin
			main_addr_i  = t.addr;
			main_wdata_i = t.data;
			main_wr_i    = t.wr;
			main_mreq_i  = 1'b1;
		end else begin
			sub_addr_i  = t.addr;
			sub_wdata_i = t.data;
			sub_wr_i    = t.wr;
		end
	endtask

	// Idle Z80 has no MREQ, idle KONAMI-1 sits on open bus
	task automatic release_bus(input int cpu);
		if (cpu == CPU_MAIN) begin
			main_mreq_i = 1'b0;
			main_wr_i   = 1'b0;
		end else begin
			sub_addr_i = 16'h4000;
			sub_wr_i   = 1'b0;
		end
	endtask

	task automatic run_test(input test_t t);
		logic [7:0] rdata;
		wait_enable(t.cpu);
		drive_bus(t);
		// Hold until just ahead of the next sampling edge
		do
			@(negedge clk_49m);
		while (!cen_of(t.cpu));
		rdata = (t.cpu == CPU_MAIN) ? main_rdata_o : sub_rdata_o;
		if (t.check == CK_READ || t.check == CK_ROM)
			compare(t.name, t.exp, rdata);
		if (t.check == CK_ROM && t.cpu == CPU_MAIN)
			compare({t.name, " addr"}, {1'b0, t.addr[14:0]}, main_rom_addr_o);
		if (t.check == CK_ROM && t.cpu == CPU_SUB)
			compare({t.name, " addr"}, {3'b000, t.addr[12:0]}, sub_rom_addr_o);
		if (t.check == CK_SOUND) begin
			compare({t.name, " strobe"}, 1'b1, cs_sounddata_o);
			compare(t.name, t.exp, sound_data_o);
		end
		@(negedge clk_49m);
		release_bus(t.cpu);
		if (t.vblank) begin
			vblank_i = 1'b1;
			@(negedge clk_49m);
			vblank_i = 1'b0;
		end
		if (t.check >= CK_TRIG) begin
			@(negedge clk_49m);
			case (t.check)
				CK_TRIG: compare(t.name, t.exp, irq_trigger_o);
				CK_FLIP: compare(t.name, t.exp, flip_o);
				CK_NMI:  compare(t.name, t.exp, nmi_n_o);
				default: compare(t.name, t.exp, irq_n_o);
			endcase
		end
	endtask

	// ============================================================
	// Stimulus table and scoring
	// ============================================================

	initial begin
		logic [7:0] bank0;
		logic [7:0] bank1;
		logic [7:0] to_sub;
		logic [7:0] to_main;
		logic [7:0] snd;
		reset          = 1'b0;
		main_addr_i    = '0;
		main_wdata_i   = '0;
		main_mreq_i    = 1'b0;
		main_wr_i      = 1'b0;
		sub_addr_i     = 16'h4000;
		sub_wdata_i    = '0;
		sub_wr_i       = 1'b0;
		controls_dip_i = '0;
		v_cnt_i        = '0;
		vblank_i       = 1'b0;
		void'($urandom(32'hd76a_443e));
		controls_dip_i = 8'($urandom);
		v_cnt_i        = 8'($urandom);
		bank0          = 8'($urandom);
		// Inverted so the two banks never hold the same byte
		bank1          = ~bank0;
		to_sub         = 8'($urandom);
		to_main        = 8'($urandom);
		snd            = 8'($urandom);

		add_test("main rom low", CPU_MAIN, 16'h1234, 0, 8'h00, rom_byte(16'h1234), CK_ROM, 0);
		add_test("main rom top", CPU_MAIN, 16'h5FA0, 0, 8'h00, rom_byte(16'h5FA0), CK_ROM, 0);
		add_test("main open 7000", CPU_MAIN, 16'h7000, 0, 8'h00, 8'hFF, CK_READ, 0);
		add_test("main open 8123", CPU_MAIN, 16'h8123, 0, 8'h00, 8'hFF, CK_READ, 0);
		add_test("wram bank0 wr", CPU_MAIN, 16'h9010, 1, bank0, 8'h00, CK_NONE, 0);
		add_test("wram bank1 wr", CPU_MAIN, 16'h9810, 1, bank1, 8'h00, CK_NONE, 0);
		add_test("wram bank0 rd", CPU_MAIN, 16'h9010, 0, 8'h00, bank0, CK_READ, 0);
		add_test("wram bank1 rd", CPU_MAIN, 16'h9810, 0, 8'h00, bank1, CK_READ, 0);
		add_test("shared main wr", CPU_MAIN, 16'hA123, 1, to_sub, 8'h00, CK_NONE, 0);
		add_test("shared sub rd", CPU_SUB, 16'h6123, 0, 8'h00, to_sub, CK_READ, 0);
		add_test("shared sub wr", CPU_SUB, 16'h7456, 1, to_main, 8'h00, CK_NONE, 0);
		add_test("shared main rd", CPU_MAIN, 16'hBC56, 0, 8'h00, to_main, CK_READ, 0);
		add_test("dip2 rd", CPU_MAIN, 16'hC000, 0, 8'h00, controls_dip_i, CK_READ, 0);
		add_test("controls rd", CPU_MAIN, 16'hC080, 0, 8'h00, controls_dip_i, CK_READ, 0);
		add_test("dip3 rd", CPU_MAIN, 16'hC100, 0, 8'h00, controls_dip_i, CK_READ, 0);
		add_test("latch rd", CPU_MAIN, 16'hC180, 0, 8'h00, 8'hFF, CK_READ, 0);
		add_test("sound data wr", CPU_MAIN, 16'hC100, 1, snd, snd, CK_SOUND, 0);
		add_test("sound irq wr", CPU_MAIN, 16'hC080, 1, 8'h00, 8'h01, CK_TRIG, 0);
		add_test("sound irq end", CPU_MAIN, 16'h1000, 0, 8'h00, 8'h00, CK_TRIG, 0);
		add_test("flip set", CPU_MAIN, 16'hC185, 1, 8'h01, 8'h01, CK_FLIP, 0);
		add_test("nmi masked", CPU_MAIN, 16'h0000, 0, 8'h00, 8'h01, CK_NMI, 1);
		add_test("nmi mask set", CPU_MAIN, 16'hC180, 1, 8'h01, 8'h00, CK_NMI, 1);
		add_test("nmi mask clr", CPU_MAIN, 16'hC180, 1, 8'h00, 8'h01, CK_NMI, 0);
		add_test("flip clr", CPU_MAIN, 16'hC185, 1, 8'h00, 8'h00, CK_FLIP, 0);
		add_test("sub rom rd", CPU_SUB, 16'hE5A7, 0, 8'h00, rom_byte(16'hE5A7), CK_ROM, 0);
		add_test("beam rd", CPU_SUB, 16'h0100, 0, 8'h00, v_cnt_i, CK_READ, 0);
		add_test("sub open 4000", CPU_SUB, 16'h4000, 0, 8'h00, 8'hFF, CK_READ, 0);
		add_test("irq masked", CPU_SUB, 16'h1FFF, 0, 8'h00, 8'h01, CK_IRQ, 1);
		add_test("irq mask set", CPU_SUB, 16'h2000, 1, 8'h01, 8'h00, CK_IRQ, 1);
		add_test("irq mask clr", CPU_SUB, 16'h3000, 1, 8'h00, 8'h01, CK_IRQ, 0);
		table_ready = 1'b1;

		repeat (RESET_CYCLES) @(negedge clk_49m);
		reset = 1'b1;
		foreach (tests[i])
			run_test(tests[i]);

		$display("Checks run: %0d, value errors: %0d, assertion errors: %0d",
			checks, errors, dut.u_checker.assert_errors);
		if (errors == 0 && dut.u_checker.assert_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Two enable periods per entry at most, plus reset
	initial begin
		wait (table_ready);
		repeat (tests.size() * 32 + RESET_CYCLES) @(posedge clk_49m);
		$display("Watchdog timeout: the test table did not finish in time");
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* gyruss_cpu_glue.f */
+incdir+rtl
rtl/gyruss_pkg.sv
rtl/ram_port_if.sv
rtl/clock_enable_gen.sv
rtl/main_bus_decoder.sv
rtl/sub_bus_decoder.sv
rtl/work_ram.sv
rtl/shared_ram.sv
rtl/gyruss_cpu_glue.sv
tb/gyruss_cpu_glue_checker.sv
tb/tb_gyruss_cpu_glue.sv

/* Bender.yml */
package:
  name: gyruss_cpu_glue

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/gyruss_pkg.sv
      - rtl/ram_port_if.sv
      - rtl/clock_enable_gen.sv
      - rtl/main_bus_decoder.sv
      - rtl/sub_bus_decoder.sv
      - rtl/work_ram.sv
      - rtl/shared_ram.sv
      - rtl/gyruss_cpu_glue.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/gyruss_cpu_glue_checker.sv
      - tb/tb_gyruss_cpu_glue.sv
